//--- Makefile
# Verilator flow for the GNSS baseband control testbench
SIM := obj_dir/tb_gnss_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_gnss_top -f project.f -Mdir obj_dir -o tb_gnss_top

run: compile
	./$(SIM) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/adc_sync.sv
/* adc_clk must stay high and low for at least two clk periods each, and adc_data
   must be stable for a few clk cycles around its rising edge */
`timescale 1ns/1ps

module adc_sync import gnss_pkg::*; (
	input  logic         clk,
	input  logic         rst_b,
	input  logic         adc_clk,
	input  sample_t      adc_data,
	output sample_beat_t sample_in
);

	logic [2:0] adc_clk_q;  // two sync stages plus one for edge detect
	sample_t    data_s1;
	sample_t    data_s2;
	sample_t    data_q;
	logic       strobe_q;
	logic       adc_rise;

	// data_s2 lines up with adc_clk_q[1]
	assign adc_rise = adc_clk_q[1] & ~adc_clk_q[2];

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			adc_clk_q <= '0;
			strobe_q  <= 1'b0;
		end else begin
			adc_clk_q <= {adc_clk_q[1:0], adc_clk};
			strobe_q  <= adc_rise;  // one strobe per adc_clk rise
		end
	end

	// ------------------------------
	// data path, no reset
	// ------------------------------
	always_ff @(posedge clk) begin
		data_s1 <= adc_data;
		data_s2 <= data_s1;
		if (adc_rise)
			data_q <= data_s2;  // value seen with the first high clock sample
	end

	assign sample_in = '{valid: strobe_q, data: data_q};

endmodule

//--- logic/baseband_ctrl.sv
/* only the global window is decoded; read data follows the address by one cycle
   whether or not host_rd is high */
`timescale 1ns/1ps

module baseband_ctrl import gnss_pkg::*; (
	input  logic         clk,
	input  logic         rst_b,
	input  logic         host_cs,
	input  logic         host_rd,
	input  logic         host_wr,
	input  host_addr_t   host_addr,
	input  host_data_t   host_d4wt,
	output host_data_t   host_d4rd,
	input  logic         te_running,
	input  logic         te_ready,
	input  logic         te_over,
	output logic         te_start,
	output logic         irq,
	output logic         buffer_enable,
	output logic         buffer_clear,
	input  fifo_status_t buffer_status
);

	localparam int FLAG_LSB = 8;  // flags and mask sit at bits 10..8

	logic       in_glb;
	logic       wr_en;
	reg_ofs_t   reg_ofs;
	meas_cnt_t  meas_number;
	meas_cnt_t  meas_count;
	meas_cnt_t  meas_count_next;
	meas_cnt_t  request_count;
	logic [2:0] int_mask;
	logic [2:0] int_flag;       // {request, meas, data ready}
	logic [2:0] flag_set;
	logic [2:0] flag_clr;
	logic       meas_wrap;
	logic       te_over_q;
	logic       start_req;
	host_data_t rd_data;

	// ------------------------------
	// host decode
	// ------------------------------
	assign in_glb     = (host_addr[13:10] == GLB_WINDOW);
	assign reg_ofs    = host_addr[4:0];
	assign wr_en      = host_cs & in_glb & host_wr;

	assign buffer_clear = wr_en & (reg_ofs == REG_FIFO_CLEAR) & host_d4wt[8];
	assign start_req    = wr_en & (reg_ofs == REG_TRACK_START) & host_d4wt[0];

	// plain control registers
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			buffer_enable <= 1'b0;
			meas_number   <= '0;
			int_mask      <= '0;
		end else if (wr_en) begin
			case (reg_ofs)
				REG_ENABLE:      buffer_enable <= host_d4wt[8];
				REG_MEAS_NUMBER: meas_number   <= host_d4wt[9:0];
				REG_INT_MASK:    int_mask      <= host_d4wt[FLAG_LSB+2:FLAG_LSB];
				default:         ;
			endcase
		end
	end

	// ------------------------------
	// measurement and request counters
	// ------------------------------
	assign meas_count_next = meas_count + 1'b1;
	assign meas_wrap       = (meas_count_next == meas_number);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			meas_count <= '0;
		else if (wr_en && reg_ofs == REG_MEAS_COUNT)
			meas_count <= host_d4wt[9:0];  // host preset
		else if (te_over)
			meas_count <= meas_wrap ? '0 : meas_count_next;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			request_count <= '0;
		else if (wr_en && reg_ofs == REG_REQUEST_COUNT)
			request_count <= host_d4wt[9:0];
		else if (te_over && request_count != '0)
			request_count <= request_count - 1'b1;  // stops at zero
	end

	// ------------------------------
	// interrupt flags
	// ------------------------------
	assign flag_set = {te_over & (request_count == meas_cnt_t'(1)),
			te_over & meas_wrap,
			te_over & te_ready};

	// write one to clear
	assign flag_clr = (wr_en && reg_ofs == REG_INT_FLAG) ?
			host_d4wt[FLAG_LSB+2:FLAG_LSB] : 3'b000;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			int_flag <= '0;
		else
			int_flag <= flag_set | (int_flag & ~flag_clr);  // set wins
	end

	assign irq = |(int_flag & int_mask);

	// auto restart two cycles after te_over or host request on the write edge
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			te_over_q <= 1'b0;
			te_start  <= 1'b0;
		end else begin
			te_over_q <= te_over;
			te_start  <= (te_over_q & ~|int_flag) | (start_req & ~te_running);
		end
	end

	// ------------------------------
	// read mux and latch
	// ------------------------------
	always_comb begin
		rd_data = '0;
		if (in_glb) begin
			case (reg_ofs)
				REG_ENABLE:        rd_data = {23'h0, buffer_enable, 8'h0};
				REG_TRACK_START:   rd_data = {31'h0, te_running};
				REG_MEAS_NUMBER:   rd_data = {22'h0, meas_number};
				REG_MEAS_COUNT:    rd_data = {22'h0, meas_count};
				REG_INT_FLAG:      rd_data = {20'h0, 1'b0, int_flag, 8'h0};  // bit 11 reserved
				REG_REQUEST_COUNT: rd_data = {22'h0, request_count};
				REG_INT_MASK:      rd_data = {20'h0, 1'b0, int_mask, 8'h0};
				REG_VERSION:       rd_data = BB_VERSION;
				REG_FIFO_STATUS:   rd_data = {16'h0, buffer_status};
				default:           rd_data = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			host_d4rd <= '0;
		else
			host_d4rd <= rd_data;
	end

endmodule

//--- logic/gnss_pkg.sv
/* types and register map of the baseband control; only the global window (bits 13..10 zero)
   is decoded, every other window reads as zero */
package gnss_pkg;

	// ------------------------------
	// widths with a meaning
	// ------------------------------
	typedef logic [13:0] host_addr_t;   // dword address, 64kB space
	typedef logic [31:0] host_data_t;
	typedef logic [7:0]  sample_t;
	typedef logic [9:0]  meas_cnt_t;    // meas number, meas count, request count
	typedef logic [4:0]  reg_ofs_t;
	typedef logic [15:0] fifo_status_t; // {overflow count, fill level}

	// one beat of the sample stream to the engine
	typedef struct packed {
		logic    valid;
		sample_t data;
	} sample_beat_t;

	// ------------------------------
	// global register window
	// ------------------------------
	localparam logic [3:0] GLB_WINDOW = 4'h0;

	localparam reg_ofs_t REG_ENABLE        = 5'd0;
	localparam reg_ofs_t REG_FIFO_CLEAR    = 5'd1;
	localparam reg_ofs_t REG_TRACK_START   = 5'd2;
	localparam reg_ofs_t REG_MEAS_NUMBER   = 5'd3;
	localparam reg_ofs_t REG_MEAS_COUNT    = 5'd4;
	localparam reg_ofs_t REG_INT_FLAG      = 5'd5;
	localparam reg_ofs_t REG_REQUEST_COUNT = 5'd6;
	localparam reg_ofs_t REG_INT_MASK      = 5'd7;
	localparam reg_ofs_t REG_VERSION       = 5'd8;
	localparam reg_ofs_t REG_FIFO_STATUS   = 5'd9;

	// major, minor, release
	localparam host_data_t BB_VERSION = {8'd1, 8'd2, 16'd5};

endpackage

//--- logic/gnss_top.sv
/* tracking engine sits outside; FIFO_DEPTH must be a power of two from 4 to 128 */
`timescale 1ns/1ps

module gnss_top import gnss_pkg::*; #(
	parameter int FIFO_DEPTH     = 16,
	parameter int SAMPLE_CREDITS = 4
) (
	input  logic         clk,
	input  logic         rst_b,
	input  logic         adc_clk,
	input  sample_t      adc_data,
	input  logic         host_cs,
	input  logic         host_rd,
	input  logic         host_wr,
	input  host_addr_t   host_addr,
	input  host_data_t   host_d4wt,
	output host_data_t   host_d4rd,
	input  logic         te_running,
	input  logic         te_ready,
	input  logic         te_over,
	output logic         te_start,
	output logic         irq,
	output sample_beat_t sample_out,
	input  logic         sample_credit
);

	sample_beat_t sample_in;
	logic         buffer_enable;
	logic         buffer_clear;
	fifo_status_t buffer_status;

	// ------------------------------
	// adc samples into clk domain
	// ------------------------------
	adc_sync u_adc_sync (
		.clk       (clk),
		.rst_b     (rst_b),
		.adc_clk   (adc_clk),
		.adc_data  (adc_data),
		.sample_in (sample_in)
	);

	sample_fifo #(
		.FIFO_DEPTH     (FIFO_DEPTH),
		.SAMPLE_CREDITS (SAMPLE_CREDITS)
	) u_sample_fifo (
		.clk           (clk),
		.rst_b         (rst_b),
		.sample_in     (sample_in),
		.buffer_enable (buffer_enable),
		.buffer_clear  (buffer_clear),
		.sample_out    (sample_out),
		.sample_credit (sample_credit),
		.buffer_status (buffer_status)
	);

	// host registers and engine sequencing
	baseband_ctrl u_baseband_ctrl (
		.clk           (clk),
		.rst_b         (rst_b),
		.host_cs       (host_cs),
		.host_rd       (host_rd),
		.host_wr       (host_wr),
		.host_addr     (host_addr),
		.host_d4wt     (host_d4wt),
		.host_d4rd     (host_d4rd),
		.te_running    (te_running),
		.te_ready      (te_ready),
		.te_over       (te_over),
		.te_start      (te_start),
		.irq           (irq),
		.buffer_enable (buffer_enable),
		.buffer_clear  (buffer_clear),
		.buffer_status (buffer_status)
	);

endmodule

//--- logic/sample_fifo.sv
/* FIFO_DEPTH is a power of two from 4 to 128; the receiver owns SAMPLE_CREDITS beats and
   returns one sample_credit pulse per beat it frees */
`timescale 1ns/1ps

module sample_fifo import gnss_pkg::*; #(
	parameter int FIFO_DEPTH     = 16,
	parameter int SAMPLE_CREDITS = 4
) (
	input  logic         clk,
	input  logic         rst_b,
	input  sample_beat_t sample_in,
	input  logic         buffer_enable,
	input  logic         buffer_clear,
	output sample_beat_t sample_out,
	input  logic         sample_credit,
	output fifo_status_t buffer_status
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam int CRED_W = $clog2(SAMPLE_CREDITS + 1);

	sample_t           mem [FIFO_DEPTH];
	logic [ADDR_W:0]   wr_ptr;
	logic [ADDR_W:0]   rd_ptr;
	logic [ADDR_W:0]   level;
	logic [7:0]        ovf_cnt;
	logic [CRED_W-1:0] credits;
	logic              full;
	logic              empty;
	logic              push;
	logic              drop;
	logic              send;
	logic              out_valid;
	sample_t           out_data;

	assign level = wr_ptr - rd_ptr;
	assign full  = level[ADDR_W];  // top bit only set at FIFO_DEPTH
	assign empty = (wr_ptr == rd_ptr);

	// samples only taken while enabled
	assign push = sample_in.valid & buffer_enable & ~buffer_clear & ~full;
	assign drop = sample_in.valid & buffer_enable & ~buffer_clear & full;
	assign send = ~empty & (credits != '0) & ~buffer_clear;

	// ------------------------------
	// storage and pointers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[ADDR_W-1:0]] <= sample_in.data;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			ovf_cnt <= '0;
		end else if (buffer_clear) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			ovf_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			if (drop && ovf_cnt != 8'hff)
				ovf_cnt <= ovf_cnt + 1'b1;  // saturates at 255
		end
	end

	// ------------------------------
	// credits and output beat
	// ------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= CRED_W'(SAMPLE_CREDITS);
		end else begin
			case ({send, sample_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // both or neither
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			out_valid <= 1'b0;
		else
			out_valid <= send;
	end

	always_ff @(posedge clk) begin
		if (send)
			out_data <= mem[rd_ptr[ADDR_W-1:0]];
	end

	assign sample_out    = '{valid: out_valid, data: out_data};
	assign buffer_status = {ovf_cnt, 8'(level)};

endmodule

//--- project.f
logic/gnss_pkg.sv
logic/adc_sync.sv
logic/sample_fifo.sv
logic/baseband_ctrl.sv
logic/gnss_top.sv
tb/tb_gnss_top.sv

//--- tb/gnss_stimulus.txt
# W addr data, R addr expect, S sample in hex; O te_ready start, H te_running start, I irq,
# A random samples, C credits, B beats in decimal; T and E open and close a named test
T registers
W 0400 ffffffff
R 0400 00000000
R 0000 00000000
W 0003 ffffffff
R 0003 000003ff
W 0007 ffffffff
R 0007 00000700
W 0006 ffffffff
R 0006 000003ff
R 0008 01020005
W 0007 00000000
W 0006 00000000
E registers
T meas_wrap
W 0003 00000003
O 0 1
O 0 1
R 0004 00000002
O 0 0
R 0004 00000000
R 0005 00000200
W 0007 00000200
I 1
W 0007 00000000
I 0
W 0005 00000200
R 0005 00000000
W 0003 00000000
E meas_wrap
T request_count
W 0006 00000002
O 0 1
R 0006 00000001
O 0 0
R 0005 00000400
O 1 0
R 0006 00000000
R 0005 00000500
W 0005 00000700
E request_count
T track_start
O 0 1
O 1 0
O 0 0
W 0005 00000100
H 1 0
H 0 1
R 0005 00000000
E track_start
T sample_stream
W 0000 00000100
R 0000 00000100
S 11
S 22
S 33
S 44
S 55
S 66
B 4
C 1
B 1
C 1
B 1
E sample_stream
T overflow_clear
C 4
A 23
B 4
R 0009 00000310
W 0001 00000100
R 0009 00000000
W 0000 00000000
A 5
R 0009 00000000
E overflow_clear

//--- tb/tb_gnss_top.sv
/* runs from the project root and reads tb/gnss_stimulus.txt; the counts in that file
   assume FIFO_DEPTH 16 and SAMPLE_CREDITS 4 */
`timescale 1ns/1ps

module tb_gnss_top import gnss_pkg::*; ();

	localparam int START_TIMEOUT = 8;    // cycles to look for te_start
	localparam int BEAT_TIMEOUT  = 100;  // cycles per expected beat
	localparam int QUIET_CYCLES  = 20;

	logic         clk, rst_b, adc_clk;
	sample_t      adc_data;
	logic         host_cs, host_rd, host_wr;
	host_addr_t   host_addr;
	host_data_t   host_d4wt;
	host_data_t   host_d4rd;
	logic         te_running, te_ready, te_over, te_start, irq;
	sample_beat_t sample_out;
	logic         sample_credit;

	sample_t exp_q[$];      // samples the FIFO should pass on, in order
	sample_t rx_q[$];       // beats seen on sample_out
	logic    enable_model;  // buffer enable as last written
	int      errors;
	integer  seed;
	string   test_name;

	gnss_top #(.FIFO_DEPTH(16), .SAMPLE_CREDITS(4)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// stream consumer, credits only come from the stimulus
	always @(negedge clk) begin
		if (rst_b && sample_out.valid)
			rx_q.push_back(sample_out.data);
	end

	// ------------------------------
	// checks
	// ------------------------------
	task automatic compare(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		errors++;
	endtask

	// ------------------------------
	// bus and engine drivers
	// ------------------------------
	task automatic host_write(input host_addr_t addr, input host_data_t data);
		@(posedge clk);
		host_cs   <= 1'b1;
		host_wr   <= 1'b1;
		host_addr <= addr;
		host_d4wt <= data;
		@(posedge clk);  // write lands here
		host_cs <= 1'b0;
		host_wr <= 1'b0;
		if (addr[13:10] == GLB_WINDOW && addr[4:0] == REG_ENABLE)
			enable_model = data[8];
		if (addr[13:10] == GLB_WINDOW && addr[4:0] == REG_FIFO_CLEAR && data[8])
			exp_q.delete();  // clear drops everything buffered
	endtask

	task automatic read_expect(input host_addr_t addr, input host_data_t expected);
		@(posedge clk);
		host_cs   <= 1'b1;
		host_rd   <= 1'b1;
		host_addr <= addr;
		@(posedge clk);
		host_cs <= 1'b0;
		host_rd <= 1'b0;
		@(negedge clk);
		compare($sformatf("read %h", addr), expected, host_d4rd);
	endtask

	task automatic pulse_te_over(input logic ready, input logic expect_start);
		int   waited;
		logic seen;
		@(posedge clk);
		te_over  <= 1'b1;
		te_ready <= ready;
		@(posedge clk);
		te_over  <= 1'b0;
		te_ready <= 1'b0;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < START_TIMEOUT) begin
			@(negedge clk);
			waited++;
			seen = te_start;
		end
		if (expect_start && !seen)
			report_failure("no te_start after te_over before timeout");
		else if (expect_start) begin
			compare("te_start delay", 2, waited);
			@(negedge clk);
			compare("te_start width", 0, 32'(te_start));
		end else if (seen)
			report_failure("te_start after te_over although a flag was set");
	endtask

	task automatic request_start(input logic running, input logic expect_start);
		@(posedge clk);
		te_running <= running;
		host_write(host_addr_t'(REG_TRACK_START), 32'h1);
		@(negedge clk);
		compare("host start", 32'(expect_start), 32'(te_start));
		@(negedge clk);
		compare("host start width", 0, 32'(te_start));
		@(posedge clk);
		te_running <= 1'b0;
	endtask

	// adc_clk high four cycles, low four cycles
	task automatic adc_sample(input sample_t value);
		@(posedge clk);
		adc_data <= value;
		adc_clk  <= 1'b1;
		repeat (4) @(posedge clk);
		adc_clk <= 1'b0;
		repeat (4) @(posedge clk);
		if (enable_model)
			exp_q.push_back(value);
	endtask

	task automatic return_credits(input int count);
		repeat (count) begin
			@(posedge clk);
			sample_credit <= 1'b1;
			@(posedge clk);
			sample_credit <= 1'b0;
		end
	endtask

	task automatic expect_beats(input int count);
		int waited;
		waited = 0;
		while (rx_q.size() < count && waited < BEAT_TIMEOUT * (count + 1)) begin
			@(negedge clk);
			waited++;
		end
		if (rx_q.size() < count)
			report_failure($sformatf("only %0d of %0d stream beats arrived before timeout",
					rx_q.size(), count));
		while (count > 0 && rx_q.size() > 0) begin
			if (exp_q.size() == 0)
				report_failure("stream beat without a matching ADC sample");
			else
				compare("stream beat", 32'(exp_q.pop_front()), 32'(rx_q[0]));
			void'(rx_q.pop_front());
			count--;
		end
		repeat (QUIET_CYCLES) @(negedge clk);  // nothing past the credits
		if (rx_q.size() != 0)
			report_failure($sformatf("%0d stream beats more than expected", rx_q.size()));
		rx_q.delete();
	endtask

	// ------------------------------
	// stimulus file interpreter
	// ------------------------------
	initial begin
		int              fd;
		int              n;
		int              test_errors;
		int              passed;
		int              failed;
		string           op;
		logic [8*32-1:0] tok;
		logic [8*128-1:0] rest;
		logic [31:0]     a;
		logic [31:0]     b;

		rst_b = 1'b0;
		{adc_clk, adc_data, sample_credit} = '0;
		{host_cs, host_rd, host_wr, host_addr, host_d4wt} = '0;
		{te_running, te_ready, te_over} = '0;
		enable_model = 1'b0;
		errors       = 0;
		passed       = 0;
		failed       = 0;
		test_errors  = 0;
		seed         = 32'h15b504f9;
		test_name    = "reset";

		repeat (5) @(posedge clk);
		rst_b <= 1'b1;
		@(negedge clk);
		compare("host_d4rd", 0, host_d4rd);
		compare("te_start irq valid", 0, 32'({te_start, irq, sample_out.valid}));

		fd = $fopen("tb/gnss_stimulus.txt", "r");
		if (fd == 0)
			report_failure("cannot open tb/gnss_stimulus.txt");
		else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tok);
				if (n != 1)
					break;
				op = string'(tok);
				case (op)
					"#": n = $fgets(rest, fd);  // comment line
					"T": begin
						n = $fscanf(fd, "%s", tok);
						test_name   = string'(tok);
						test_errors = errors;
					end
					"E": begin
						n = $fscanf(fd, "%s", tok);
						if (errors == test_errors) begin
							passed++;
							$display("test %s: ok", string'(tok));
						end else begin
							failed++;
							$display("test %s: %0d error(s)", string'(tok), errors - test_errors);
						end
					end
					"W": begin
						n = $fscanf(fd, "%h %h", a, b);
						host_write(a[13:0], b);
					end
					"R": begin
						n = $fscanf(fd, "%h %h", a, b);
						read_expect(a[13:0], b);
					end
					"O": begin
						n = $fscanf(fd, "%d %d", a, b);
						pulse_te_over(a[0], b[0]);
					end
					"H": begin
						n = $fscanf(fd, "%d %d", a, b);
						request_start(a[0], b[0]);
					end
					"I": begin
						n = $fscanf(fd, "%d", a);
						@(negedge clk);
						compare("irq", a, 32'(irq));
					end
					"S": begin
						n = $fscanf(fd, "%h", a);
						adc_sample(a[7:0]);
					end
					"A": begin
						n = $fscanf(fd, "%d", a);
						repeat (a) adc_sample(sample_t'($random(seed)));
					end
					"C": begin
						n = $fscanf(fd, "%d", a);
						return_credits(a);
					end
					"B": begin
						n = $fscanf(fd, "%d", a);
						expect_beats(a);
					end
					default: report_failure($sformatf("unknown operation %s in stimulus", op));
				endcase
			end
			$fclose(fd);
		end

		if (rx_q.size() != 0)
			report_failure("stream beats left unchecked at the end");
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0 && failed == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
